// ==== filelist.f ====
+incdir+.
uart_pkg.sv
calc_pkg.sv
calc_cmd_if.sv
uart_rx.sv
cmd_parser.sv
reply_sequencer.sv
uart_tx.sv
calc_uart_top.sv
tb_calc_uart.sv

// ==== Bender.yml ====
package:
  name: calc_uart

sources:
  - files:
      - uart_pkg.sv
      - calc_pkg.sv
      - calc_cmd_if.sv
      - uart_rx.sv
      - cmd_parser.sv
      - reply_sequencer.sv
      - uart_tx.sv
      - calc_uart_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_calc_uart.sv

// ==== tb_uart_bfm.svh ====
/* uart line models for the testbench
   drives 8N1 frames on i_rx and collects the frames seen on o_tx */

`ifndef TB_UART_BFM_SVH
`define TB_UART_BFM_SVH

uart_pkg::byte_t cap_q[$];   // frames captured from o_tx, oldest first

// one bit on i_rx, 2 ns after the edge, BIT_CLKS cycles long
task automatic drive_bit(input logic v);
    @(posedge CLKOP);
    #2 i_rx = v;
    repeat (BIT_CLKS - 1) @(posedge CLKOP);
endtask

// ------------------------------
// full frame, start, 8 data lsb first, stop
task automatic send_byte(input uart_pkg::byte_t b);
    drive_bit(1'b0);
    for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
        drive_bit(b[i]);
    end
    drive_bit(1'b1);
endtask

// runs forever, samples o_tx at mid bit on falling clock edges
task automatic capture_frames();
    uart_pkg::byte_t b;
    forever begin
        @(negedge o_tx);
        repeat (BIT_CLKS / 2) @(negedge CLKOP);   // middle of start bit
        if (o_tx !== 1'b0) begin
            $display("start bit on o_tx ended early at %0t ns", $time);
            err_cnt++;
        end else begin
            for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
                repeat (BIT_CLKS) @(negedge CLKOP);
                b[i] = o_tx;
            end
            repeat (BIT_CLKS) @(negedge CLKOP);   // middle of stop bit
            if (o_tx !== 1'b1) begin
                $display("stop bit on o_tx was low at %0t ns", $time);
                err_cnt++;
            end else begin
                cap_q.push_back(b);
            end
        end
    end
endtask

`endif

// ==== tb_calc_uart.sv ====
/* serial calculator testbench
   directed echo, add, subtract, malformed and random command tests */

`timescale 1ns/1ns
`default_nettype none

module tb_calc_uart;

    localparam int CLK_NS     = 20;
    localparam int BIT_CLKS   = 16;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;   // start + 8 + stop
    localparam int SENT_BYTES = 85;              // all commands of all tests
    localparam int EXP_BYTES  = 160;             // echoes plus replies
    localparam int WATCHDOG_NS = (SENT_BYTES + EXP_BYTES) * FRAME_CLKS * CLK_NS * 2;

    logic   CLKOP;
    logic   i_rst;
    logic   i_rx;
    wire    o_tx;
    int     err_cnt = 0;
    int     tests_ok = 0;
    int     tests_bad = 0;
    integer seed = 99941;

    `include "tb_uart_bfm.svh"

    calc_uart_top #(.CLKS_PER_BIT(BIT_CLKS)) uut (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_rx(i_rx), .o_tx(o_tx)
    );

    initial begin
        CLKOP = 1'b0;
        forever #(CLK_NS / 2) CLKOP = ~CLKOP;
    end

    // ------------------------------
    // checks and helpers
    // ------------------------------
    task automatic check_byte(input uart_pkg::byte_t exp, input uart_pkg::byte_t got,
                              input string what);
        if (got !== exp) begin
            $display("Error: %0t ns: %s, expected 0x%02h got 0x%02h", $time, what, exp, got);
            err_cnt++;
        end
    endtask

    task automatic wait_frames(input int n, output bit ok);
        int waited;
        waited = 0;
        while (cap_q.size() < n && waited < (n + 2) * FRAME_CLKS * 2) begin
            @(posedge CLKOP);
            waited++;
        end
        ok = (cap_q.size() >= n);
    endtask

    // sign then two digits of the magnitude
    function automatic string calc_reply(input int a, input int b, input bit sub);
        int r;
        int m;
        r = sub ? a - b : a + b;
        m = (r < 0) ? -r : r;
        return $sformatf("%s%0d%0d", (r < 0) ? "-" : "+", m / 10, m % 10);
    endfunction

    // send, expect every byte echoed, then the reply, then silence
    task automatic run_cmd(input string cmd_s, input string reply_s);
        string           exp_s;
        bit              ok;
        uart_pkg::byte_t got;
        exp_s = {cmd_s, reply_s};
        for (int i = 0; i < cmd_s.len(); i++) begin
            send_byte(cmd_s[i]);
        end
        wait_frames(exp_s.len(), ok);
        if (!ok) begin
            $display("no full reply to \"%s\", got %0d of %0d frames",
                     cmd_s, cap_q.size(), exp_s.len());
            err_cnt++;
            cap_q.delete();
        end else begin
            for (int i = 0; i < exp_s.len(); i++) begin
                got = cap_q.pop_front();
                check_byte(exp_s[i], got, $sformatf("char %0d for \"%s\"", i, cmd_s));
            end
            repeat (2 * FRAME_CLKS) @(posedge CLKOP);   // line must stay quiet
            if (cap_q.size() != 0) begin
                $display("unexpected extra frames on o_tx after \"%s\"", cmd_s);
                err_cnt++;
                cap_q.delete();
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_echo();
        int e0;
        e0 = err_cnt;
        run_cmd("x", "");
        report_test("echo", e0);
    endtask

    task automatic test_add();
        int e0;
        e0 = err_cnt;
        run_cmd("34+", "+07");
        run_cmd("99+", "+18");      // largest sum
        report_test("add", e0);
    endtask

    task automatic test_sub();
        int e0;
        e0 = err_cnt;
        run_cmd("27-", "-05");
        run_cmd("44-", "+00");      // zero is plus
        report_test("sub", e0);
    endtask

    task automatic test_malformed();
        int e0;
        e0 = err_cnt;
        run_cmd("a3+", "");         // bad first digit
        run_cmd("3a+", "");         // bad second digit
        run_cmd("34x", "");         // bad operator
        run_cmd("58-", "-03");      // parser recovered
        report_test("malformed", e0);
    endtask

    task automatic test_random();
        int e0;
        int a;
        int b;
        bit sub;
        e0 = err_cnt;
        for (int k = 0; k < 20; k++) begin
            a   = {$random(seed)} % 10;
            b   = {$random(seed)} % 10;
            sub = $random(seed) & 1;
            run_cmd($sformatf("%0d%0d%s", a, b, sub ? "-" : "+"), calc_reply(a, b, sub));
        end
        report_test("random", e0);
    endtask

    // ------------------------------
    // main sequence and watchdog
    // ------------------------------
    initial begin
        i_rst = 1'b1;
        i_rx  = 1'b1;               // idle line
        repeat (3) @(posedge CLKOP);
        #2 i_rst = 1'b0;
        fork
            capture_frames();
        join_none
        repeat (2) @(posedge CLKOP);
        test_echo();
        test_add();
        test_sub();
        test_malformed();
        test_random();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_ok, tests_bad, err_cnt);
        if (err_cnt == 0 && tests_bad == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule : tb_calc_uart

`default_nettype wire

// ==== calc_uart_top.sv ====
/* serial calculator top
   receiver, command parser, reply sequencer and transmitter on CLKOP */

`timescale 1ns/1ns
`default_nettype none

module calc_uart_top #(
    parameter int CLKS_PER_BIT = uart_pkg::DEF_CLKS_PER_BIT
) (
    input  wire logic CLKOP,
    input  wire logic i_rst,
    input  wire logic i_rx,
    output logic      o_tx
);

    uart_pkg::byte_t rx_data;    // received byte, also the echo
    logic            rx_valid;
    uart_pkg::byte_t tx_data;
    logic            tx_valid;
    logic            tx_ready;

    calc_cmd_if cmd_if ();       // parser -> sequencer

    // ------------------------------
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .CLKOP(CLKOP), .i_rst(i_rst), .i_rx(i_rx),
        .o_rx_data(rx_data), .o_rx_valid(rx_valid)
    );

    cmd_parser u_parser (
        .CLKOP(CLKOP), .i_rst(i_rst),
        .i_rx_data(rx_data), .i_rx_valid(rx_valid), .cmd(cmd_if.parser)
    );

    reply_sequencer u_seq (
        .CLKOP(CLKOP), .i_rst(i_rst),
        .i_echo_data(rx_data), .i_echo_valid(rx_valid), .cmd(cmd_if.sequencer),
        .o_tx_data(tx_data), .o_tx_valid(tx_valid), .i_tx_ready(tx_ready)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .CLKOP(CLKOP), .i_rst(i_rst),
        .i_tx_data(tx_data), .i_tx_valid(tx_valid),
        .o_tx_ready(tx_ready), .o_tx(o_tx)
    );

endmodule : calc_uart_top

`default_nettype wire

// ==== uart_tx.sv ====
/* uart transmitter
   8N1 serializer, takes one byte per valid/ready transfer when idle */

`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic            CLKOP,
    input  wire logic            i_rst,
    input  wire uart_pkg::byte_t i_tx_data,
    input  wire logic            i_tx_valid,
    output logic                 o_tx_ready,
    output logic                 o_tx
);

    localparam int FRAME_BITS = uart_pkg::DATA_BITS + 2;  // start + data + stop
    localparam int CNT_W      = $clog2(CLKS_PER_BIT);
    localparam int BIT_W      = $clog2(FRAME_BITS);

    logic [CNT_W-1:0]             cnt;
    logic [BIT_W-1:0]             bit_idx;   // bit now on the line
    logic [uart_pkg::DATA_BITS:0] shift;     // data then stop

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            o_tx_ready <= 1'b1;
            o_tx       <= uart_pkg::LINE_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
        end else if (o_tx_ready) begin
            if (i_tx_valid) begin
                o_tx_ready <= 1'b0;
                o_tx       <= uart_pkg::LINE_START;   // start bit right away
                shift      <= {uart_pkg::LINE_IDLE, i_tx_data};
                cnt        <= '0;
                bit_idx    <= '0;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin  // bit boundary
                cnt <= '0;
                if (bit_idx == BIT_W'(FRAME_BITS - 1)) begin
                    o_tx_ready <= 1'b1;              // stop bit done
                end else begin
                    o_tx    <= shift[0];
                    shift   <= {uart_pkg::LINE_IDLE, shift[uart_pkg::DATA_BITS:1]};
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // idle line whenever a new byte may be taken
    a_idle_high: assert property (@(posedge CLKOP) disable iff (i_rst)
        o_tx_ready |-> o_tx == uart_pkg::LINE_IDLE)
        else $error("tx line low while transmitter idle");

endmodule : uart_tx

`default_nettype wire

// ==== reply_sequencer.sv ====
/* reply sequencer
   computes the result and merges echo and result chars toward the tx */

`timescale 1ns/1ns
`default_nettype none

module reply_sequencer (
    input  wire logic            CLKOP,
    input  wire logic            i_rst,
    input  wire uart_pkg::byte_t i_echo_data,
    input  wire logic            i_echo_valid,
    calc_cmd_if.sequencer        cmd,
    output uart_pkg::byte_t      o_tx_data,
    output logic                 o_tx_valid,
    input  wire logic            i_tx_ready
);

    typedef enum logic [1:0] {S_IDLE, S_SIGN, S_TENS, S_ONES} state_t;

    state_t            state;
    uart_pkg::byte_t   echo_q;    // one byte echo buffer
    logic              echo_full;
    calc_pkg::result_t opa, opb, result_q, neg;
    logic [4:0]        mag;       // |result|, 0..18
    logic              ge10;
    logic [4:0]        ones;

    assign opa  = {2'b00, cmd.cmd_a};
    assign opb  = {2'b00, cmd.cmd_b};
    assign neg  = -result_q;
    assign mag  = result_q[5] ? neg[4:0] : result_q[4:0];
    assign ge10 = (mag >= 5'd10);
    assign ones = ge10 ? mag - 5'd10 : mag;

    assign cmd.cmd_ready = (state == S_IDLE);  // busy for whole reply

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            state      <= S_IDLE;
            echo_full  <= 1'b0;
            o_tx_valid <= 1'b0;
        end else begin
            if (o_tx_valid && i_tx_ready) o_tx_valid <= 1'b0;

            // ------------------------------
            // next char, echo first
            if (!o_tx_valid) begin
                if (echo_full) begin
                    o_tx_data  <= echo_q;
                    o_tx_valid <= 1'b1;
                    echo_full  <= 1'b0;
                end else if (state != S_IDLE) begin
                    o_tx_valid <= 1'b1;
                    case (state)
                        S_SIGN:  o_tx_data <= result_q[5] ? calc_pkg::ASCII_MINUS
                                                          : calc_pkg::ASCII_PLUS;
                        S_TENS:  o_tx_data <= calc_pkg::ASCII_ZERO + {7'd0, ge10};
                        default: o_tx_data <= calc_pkg::ASCII_ZERO + {3'd0, ones};
                    endcase
                    state <= (state == S_ONES) ? S_IDLE : state_t'(state + 2'd1);
                end
            end

            if (i_echo_valid) begin           // new strobe overwrites
                echo_q    <= i_echo_data;
                echo_full <= 1'b1;
            end

            if (cmd.cmd_valid && cmd.cmd_ready) begin
                result_q <= (cmd.cmd_op == calc_pkg::OP_SUB) ? opa - opb : opa + opb;
                state    <= S_SIGN;
            end
        end
    end

    // char held on the line to the tx until taken
    a_tx_hold: assert property (@(posedge CLKOP) disable iff (i_rst)
        o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data))
        else $error("tx char dropped before acceptance");

endmodule : reply_sequencer

`default_nettype wire

// ==== cmd_parser.sv ====
/* command parser
   digit, digit, operator sequence turned into one calculator command */

`timescale 1ns/1ns
`default_nettype none

module cmd_parser (
    input  wire logic            CLKOP,
    input  wire logic            i_rst,
    input  wire uart_pkg::byte_t i_rx_data,
    input  wire logic            i_rx_valid,
    calc_cmd_if.parser           cmd
);

    logic [1:0]       pos;         // 0 first digit, 1 second, 2 operator
    calc_pkg::digit_t dig_a;
    calc_pkg::digit_t dig_b;       // held apart from a pending command
    uart_pkg::byte_t  diff;        // byte minus '0'
    logic             is_digit;
    logic             is_op;

    assign diff     = i_rx_data - calc_pkg::ASCII_ZERO;
    assign is_digit = (diff < 8'd10);  // below '0' wraps high
    assign is_op    = (i_rx_data == calc_pkg::ASCII_PLUS) ||
                      (i_rx_data == calc_pkg::ASCII_MINUS);

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            pos           <= 2'd0;
            cmd.cmd_valid <= 1'b0;
        end else begin
            if (cmd.cmd_valid && cmd.cmd_ready) cmd.cmd_valid <= 1'b0;  // taken

            if (i_rx_valid) begin
                case (pos)
                    2'd0: if (is_digit) begin
                        dig_a <= diff[3:0];
                        pos   <= 2'd1;
                    end
                    2'd1: pos <= is_digit ? 2'd2 : 2'd0;
                    default: begin
                        pos <= 2'd0;   // operator or not, start over
                        // slot must be free or freeing now, else drop
                        if (is_op && (!cmd.cmd_valid || cmd.cmd_ready)) begin
                            cmd.cmd_valid <= 1'b1;
                            cmd.cmd_a     <= dig_a;
                            cmd.cmd_b     <= dig_b;
                            cmd.cmd_op    <= (i_rx_data == calc_pkg::ASCII_MINUS) ?
                                             calc_pkg::OP_SUB : calc_pkg::OP_ADD;
                        end
                    end
                endcase
                if (pos == 2'd1 && is_digit) dig_b <= diff[3:0];
            end
        end
    end

    // ---------------------------------
    // handshake hold rule toward sequencer
    a_cmd_hold: assert property (@(posedge CLKOP) disable iff (i_rst)
        cmd.cmd_valid && !cmd.cmd_ready |=>
            cmd.cmd_valid && $stable({cmd.cmd_a, cmd.cmd_b, cmd.cmd_op}))
        else $error("command changed before it was accepted");

endmodule : cmd_parser

`default_nettype wire

// ==== uart_rx.sv ====
/* uart receiver
   oversampled 8N1 input, one byte strobe per good frame */

`timescale 1ns/1ns
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  wire logic          CLKOP,
    input  wire logic          i_rst,
    input  wire logic          i_rx,
    output uart_pkg::byte_t    o_rx_data,
    output logic               o_rx_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

    state_t           state;
    logic [1:0]       rx_sync;     // metastability flops
    logic             rx_s;
    logic [CNT_W-1:0] cnt;         // cycles within a bit
    logic [BIT_W-1:0] bit_idx;
    uart_pkg::byte_t  shift;

    assign rx_s = rx_sync[1];

    always_ff @(posedge CLKOP) begin
        if (i_rst) begin
            rx_sync    <= {2{uart_pkg::LINE_IDLE}};
            state      <= S_IDLE;
            cnt        <= '0;
            bit_idx    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[0], i_rx};
            o_rx_valid <= 1'b0;              // strobe, default low
            cnt        <= cnt + 1'b1;
            case (state)
                S_IDLE: begin
                    cnt <= '0;
                    if (rx_s == uart_pkg::LINE_START) state <= S_START;
                end
                S_START: if (cnt == CNT_W'(CLKS_PER_BIT/2 - 1)) begin
                    cnt     <= '0;           // now aligned to mid-bit
                    bit_idx <= '0;
                    // glitch shorter than half a bit goes back to idle
                    state   <= (rx_s == uart_pkg::LINE_START) ? S_DATA : S_IDLE;
                end
                S_DATA: if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    cnt     <= '0;
                    shift   <= {rx_s, shift[uart_pkg::DATA_BITS-1:1]};  // lsb first
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == BIT_W'(uart_pkg::DATA_BITS - 1)) state <= S_STOP;
                end
                S_STOP: if (cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    state <= S_IDLE;
                    if (rx_s == uart_pkg::LINE_IDLE) begin  // framing ok
                        o_rx_data  <= shift;
                        o_rx_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // one strobe per frame, never two back to back
    a_rx_strobe_single: assert property (@(posedge CLKOP) disable iff (i_rst)
        o_rx_valid |=> !o_rx_valid)
        else $error("uart_rx strobe held for two cycles");

endmodule : uart_rx

`default_nettype wire

// ==== calc_cmd_if.sv ====
/* command interface
   one parsed calculator command, valid/ready from parser to sequencer */

`timescale 1ns/1ns
`default_nettype none

interface calc_cmd_if;

    logic             cmd_valid;
    logic             cmd_ready;
    calc_pkg::digit_t cmd_a;     // first operand
    calc_pkg::digit_t cmd_b;     // second operand
    calc_pkg::op_e    cmd_op;

    // parser side, source of commands
    modport parser (output cmd_valid, cmd_a, cmd_b, cmd_op, input cmd_ready);

    // sequencer side, sink
    modport sequencer (input cmd_valid, cmd_a, cmd_b, cmd_op, output cmd_ready);

endinterface : calc_cmd_if

`default_nettype wire

// ==== calc_pkg.sv ====
/* calculator package
   ascii codes, operator enum, operand and result types */

`default_nettype none

package calc_pkg;

    // ------------------------------
    // ascii codes
    // ------------------------------
    localparam logic [7:0] ASCII_ZERO  = 8'h30;  // '0'
    localparam logic [7:0] ASCII_PLUS  = 8'h2b;  // '+'
    localparam logic [7:0] ASCII_MINUS = 8'h2d;  // '-'

    // single decimal operand, 0..9
    typedef logic [3:0] digit_t;

    // operator, one bit
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } op_e;

    // ------------------------------
    // arithmetic
    // ------------------------------
    // range -9 .. 18, fits 6 bit two's complement
    typedef logic signed [5:0] result_t;

endpackage : calc_pkg

`default_nettype wire

// ==== uart_pkg.sv ====
/* uart line package
   serial frame format constants and the data byte type */

`default_nettype none

package uart_pkg;

    // ------------------------------
    // frame format, 8N1
    // ------------------------------
    localparam int DATA_BITS = 8;          // data bits per frame, lsb first

    localparam int DEF_CLKS_PER_BIT = 16;  // CLKOP cycles per bit unless overridden

    localparam logic LINE_IDLE  = 1'b1;    // idle and stop level
    localparam logic LINE_START = 1'b0;    // start bit level

    // one byte on the serial line
    typedef logic [DATA_BITS-1:0] byte_t;

endpackage : uart_pkg

`default_nettype wire
